//--- common/decompose_pkg.sv
// Decompose constants for the q-1/32 choice of gamma2 only, other gamma2 sets are not covered
package decompose_pkg;

    // ------------------------------------------------------------------------
    // Modulus and decomposition constants
    // ------------------------------------------------------------------------

    // Dilithium prime, fits in 23 bits
    localparam int DILITHIUM_Q = 8380417;

    // Low-order rounding range, (q-1)/32
    localparam int GAMMA2 = (DILITHIUM_Q - 1) / 32;

    // 2*gamma2 equals 2^19 - 512, which the fold in the modulo stage relies on
    localparam int TWO_GAMMA2 = 2 * GAMMA2;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    // Input coefficient width
    localparam int COEFF_W = 23;

    // Width of a value reduced modulo 2*gamma2
    localparam int MOD_W = 19;

    // Signed low part, wide enough for -gamma2 after the wrap correction
    localparam int R0_W = 20;

    // High part, r1 is at most 15
    localparam int R1_W = 4;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    typedef logic [COEFF_W-1:0] coeff_t;
    typedef logic [MOD_W-1:0] mod_t;
    typedef logic signed [R0_W-1:0] r0_t;
    typedef logic [R1_W-1:0] r1_t;

    // Result of one lane, r1 in the upper bits and r0 below it
    typedef struct packed {
        r1_t r1;
        r0_t r0;
    } decomp_t;

endpackage

//--- logic/coeff_distributor.sv
// Registers one coefficient vector per strobe, values >= q are flagged but passed on unchanged
module coeff_distributor #(
    parameter int LANES = 4
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  in_en_i,
    input  decompose_pkg::coeff_t coeff_i [LANES],
    output logic                  lane_en_o,
    output decompose_pkg::coeff_t lane_coeff_o [LANES],
    output logic                  range_err_o
);
    import decompose_pkg::*;

    logic over_q;

    // Any coefficient outside [0, q) marks the whole vector
    always_comb begin
        over_q = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (coeff_i[k] >= DILITHIUM_Q) begin
                over_q = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Input register stage
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane_en_o    <= 1'b0;
            range_err_o  <= 1'b0;
            lane_coeff_o <= '{default: '0};
        end else if (zeroize_i) begin
            lane_en_o    <= 1'b0;
            range_err_o  <= 1'b0;
            lane_coeff_o <= '{default: '0};
        end else begin
            // The range flag is a strobe that travels with the lane enable
            lane_en_o   <= in_en_i;
            range_err_o <= in_en_i & over_q;
            if (in_en_i) begin
                lane_coeff_o <= coeff_i;
            end
        end
    end

endmodule

//--- decompose_lane/mod_2gamma2.sv
// Two-stage r mod 2*gamma2 for any 23-bit input, result valid only in the cycle ready_o is high
module mod_2gamma2 (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  add_en_i,
    input  decompose_pkg::coeff_t opa_i,
    output decompose_pkg::mod_t   res_o,
    output logic                  ready_o
);
    import decompose_pkg::*;

    // Complement of 2*gamma2, added with a carry-in of one to subtract
    localparam mod_t TWO_GAMMA2_INV = ~mod_t'(TWO_GAMMA2);

    logic [MOD_W:0] fold_sum;
    mod_t           sum_q;
    logic           carry_q;
    logic [MOD_W:0] sub_sum;

    // ------------------------------------------------------------------------
    // Stage 1: fold the top bits
    // ------------------------------------------------------------------------

    // Since 2^19 is 512 mod 2*gamma2, bits 22:19 fold back in at weight 512
    assign fold_sum = {1'b0, opa_i[MOD_W-1:0]}
                    + (MOD_W+1)'({opa_i[COEFF_W-1:MOD_W], 9'd0});

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
        end else if (zeroize_i) begin
            sum_q   <= '0;
            carry_q <= 1'b0;
        end else if (add_en_i) begin
            sum_q   <= fold_sum[MOD_W-1:0];
            carry_q <= fold_sum[MOD_W];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_o <= 1'b0;
        end else if (zeroize_i) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= add_en_i;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: one conditional subtraction
    // ------------------------------------------------------------------------

    assign sub_sum = {1'b0, sum_q} + {1'b0, TWO_GAMMA2_INV} + (MOD_W+1)'(1);

    // When the fold carried, the subtraction always borrows, when it did not
    // the subtraction is kept only if it does not borrow
    assign res_o = (carry_q ^ sub_sum[MOD_W]) ? sub_sum[MOD_W-1:0] : sum_q;

    // A single subtraction must be enough to land below 2*gamma2
    a_res_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        ready_o |-> (res_o < TWO_GAMMA2));

endmodule

//--- decompose_lane/decompose_lane.sv
// One Decompose lane for in-range inputs, the result for a coefficient >= q is not defined
module decompose_lane (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   en_i,
    input  decompose_pkg::coeff_t  coeff_i,
    output decompose_pkg::decomp_t res_o,
    output logic                   rdy_o
);
    import decompose_pkg::*;

    // r - r0 is always a multiple of 512*1023, so only bits above 9 matter
    localparam int MULT_STEP = TWO_GAMMA2 / 512;

    mod_t                    mod_res;
    logic                    mod_rdy;
    coeff_t                  coeff_q;
    r0_t                     r0_c;
    logic signed [COEFF_W:0] diff;
    logic [COEFF_W-9:0]      diff_hi;
    r1_t                     r1_c;
    logic                    wrap;
    decomp_t                 res_c;

    mod_2gamma2 u_mod (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .add_en_i  (en_i),
        .opa_i     (coeff_i),
        .res_o     (mod_res),
        .ready_o   (mod_rdy)
    );

    // Keep r alongside the modulo pipeline so both line up at mod_rdy
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            coeff_q <= '0;
        end else if (zeroize_i) begin
            coeff_q <= '0;
        end else if (en_i) begin
            coeff_q <= coeff_i;
        end
    end

    // ------------------------------------------------------------------------
    // Centering and high part
    // ------------------------------------------------------------------------

    // Move r0 into (-gamma2, gamma2]
    assign r0_c = (mod_res > GAMMA2) ? r0_t'({1'b0, mod_res}) - r0_t'(TWO_GAMMA2)
                                     : r0_t'({1'b0, mod_res});

    // Never negative, since r0 is at most r whenever it is positive
    assign diff    = $signed({1'b0, coeff_q}) - r0_c;
    assign diff_hi = diff[COEFF_W:9];

    // r1 is the largest j with j*2*gamma2 <= r - r0, found without a divider
    always_comb begin
        r1_c = '0;
        for (int j = 1; j < 2**R1_W; j++) begin
            if (diff_hi >= j * MULT_STEP) begin
                r1_c = r1_t'(j);
            end
        end
    end

    // r - r0 = q-1 would give r1 = 16, which folds to r1 = 0 with r0 one lower
    assign wrap     = (diff == DILITHIUM_Q - 1);
    assign res_c.r1 = wrap ? r1_t'(0) : r1_c;
    assign res_c.r0 = wrap ? r0_c - r0_t'(1) : r0_c;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res_o <= '0;
            rdy_o <= 1'b0;
        end else if (zeroize_i) begin
            res_o <= '0;
            rdy_o <= 1'b0;
        end else begin
            rdy_o <= mod_rdy;
            if (mod_rdy) begin
                res_o <= res_c;
            end
        end
    end

    // r1 and r0 recombine to r, or to r - q once the wrap correction applied
    a_res_recombine: assert property (@(posedge clk) disable iff (!reset_n)
        rdy_o |-> (int'(res_o.r1) * TWO_GAMMA2 + int'(res_o.r0) == int'($past(coeff_q)))
               || (int'(res_o.r1) * TWO_GAMMA2 + int'(res_o.r0)
                   == int'($past(coeff_q)) - DILITHIUM_Q));

endmodule

//--- logic/decompose_collector.sv
// Gathers lane results, flags are strobes valid only with out_en_o and there is no back-pressure
module decompose_collector #(
    parameter int LANES = 4,
    parameter int BETA  = 196
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   lane_rdy_i,
    input  decompose_pkg::decomp_t lane_res_i [LANES],
    input  logic                   range_err_i,
    output logic                   out_en_o,
    output decompose_pkg::decomp_t res_o [LANES],
    output logic                   norm_fail_o,
    output logic                   range_err_o
);
    import decompose_pkg::*;

    // Any |r0| at or above this bound fails the infinity-norm test
    localparam int NORM_BOUND = GAMMA2 - BETA;

    logic [1:0] range_sr;
    logic       norm_hit;

    function automatic logic [R0_W-1:0] abs_r0(input r0_t v);
        return (v < 0) ? -v : v;
    endfunction

    // Test every lane of the current vector against the bound
    always_comb begin
        norm_hit = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (abs_r0(lane_res_i[k].r0) >= NORM_BOUND) begin
                norm_hit = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Flag alignment and output register
    // ------------------------------------------------------------------------

    // Two stages match the modulo stage and the lane output register
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            range_sr    <= '0;
            out_en_o    <= 1'b0;
            norm_fail_o <= 1'b0;
            range_err_o <= 1'b0;
            res_o       <= '{default: '0};
        end else if (zeroize_i) begin
            range_sr    <= '0;
            out_en_o    <= 1'b0;
            norm_fail_o <= 1'b0;
            range_err_o <= 1'b0;
            res_o       <= '{default: '0};
        end else begin
            range_sr    <= {range_sr[0], range_err_i};
            out_en_o    <= lane_rdy_i;
            norm_fail_o <= lane_rdy_i & norm_hit;
            range_err_o <= lane_rdy_i & range_sr[1];
            if (lane_rdy_i) begin
                res_o <= lane_res_i;
            end
        end
    end

    a_flags_qualified: assert property (@(posedge clk) disable iff (!reset_n)
        !out_en_o |-> !norm_fail_o && !range_err_o);

    // A delayed range flag must meet a lane result, otherwise the lane depth has changed
    a_range_meets_rdy: assert property (@(posedge clk) disable iff (!reset_n)
        range_sr[1] |-> lane_rdy_i);

endmodule

//--- logic/decompose_top.sv
// Decompose for gamma2 = (q-1)/32 with four cycles of fixed latency and no input back-pressure
module decompose_top #(
    parameter int LANES = 4,
    parameter int BETA  = 196
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize_i,
    input  logic                   in_en_i,
    input  decompose_pkg::coeff_t  coeff_i [LANES],
    output logic                   out_en_o,
    output decompose_pkg::decomp_t res_o [LANES],
    output logic                   norm_fail_o,
    output logic                   range_err_o
);
    import decompose_pkg::*;

    logic    lane_en;
    coeff_t  lane_coeff [LANES];
    logic    range_err;
    decomp_t lane_res [LANES];
    logic    lane_rdy;

    coeff_distributor #(
        .LANES (LANES)
    ) u_distributor (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .in_en_i      (in_en_i),
        .coeff_i      (coeff_i),
        .lane_en_o    (lane_en),
        .lane_coeff_o (lane_coeff),
        .range_err_o  (range_err)
    );

    // ------------------------------------------------------------------------
    // Lanes
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        logic rdy;

        decompose_lane u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .en_i      (lane_en),
            .coeff_i   (lane_coeff[k]),
            .res_o     (lane_res[k]),
            .rdy_o     (rdy)
        );

        // All lanes run in lockstep, so lane 0 stands for the rest
        if (k == 0) begin : g_rdy
            assign lane_rdy = rdy;
        end
    end

    decompose_collector #(
        .LANES (LANES),
        .BETA  (BETA)
    ) u_collector (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .lane_rdy_i  (lane_rdy),
        .lane_res_i  (lane_res),
        .range_err_i (range_err),
        .out_en_o    (out_en_o),
        .res_o       (res_o),
        .norm_fail_o (norm_fail_o),
        .range_err_o (range_err_o)
    );

endmodule

//--- verification/decompose_tb.sv
// Testbench for decompose_top with LANES = 4 and BETA = 196, results are compared on falling edges
module decompose_tb;
    import decompose_pkg::*;

    localparam int LANES = 4;
    localparam int BETA  = 196;

    // Cycles from the input strobe to the matching output strobe
    localparam int LATENCY = 4;

    // Cycle budget per section, sparse strobes use at most five cycles each
    localparam int BOUND_VECS  = 12;
    localparam int RAND_VECS   = 200;
    localparam int SPARSE_VECS = 40;
    localparam int RUN_CYCLES  = BOUND_VECS + RAND_VECS + 5 * SPARSE_VECS + 6 + 16 + 20
                               + 7 * 14 + 10;
    localparam int TIMEOUT     = (RUN_CYCLES + 20) * 100;

    typedef coeff_t [LANES-1:0] coeff_vec_t;

    // Expected outcome of one strobe, skip marks lanes whose input was >= q
    typedef struct packed {
        decomp_t [LANES-1:0] res;
        logic [LANES-1:0]    skip;
        logic                norm;
        logic                rng;
        int                  due;
    } expect_t;

    logic       clk;
    logic       reset_n;
    logic       zeroize;
    logic       in_en;
    coeff_t     coeff [LANES];
    logic       out_en;
    decomp_t    res [LANES];
    logic       norm_fail;
    logic       range_err;
    expect_t    exp_q [$];
    int         seed = 32'h2cc0_c401;
    int         value_errors = 0;
    int         misc_errors = 0;
    coeff_vec_t pend;
    int         pend_n = 0;
    int         cycle_cnt = 0;

    decompose_top #(
        .LANES (LANES),
        .BETA  (BETA)
    ) DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize),
        .in_en_i     (in_en),
        .coeff_i     (coeff),
        .out_en_o    (out_en),
        .res_o       (res),
        .norm_fail_o (norm_fail),
        .range_err_o (range_err)
    );

    always #50 clk = ~clk;

    // Rising edges seen so far, used to time each result against its strobe
    always @(posedge clk) begin
        cycle_cnt++;
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    // Centered remainder, then r1 from r - r0 with the q-1 wrap folded to zero
    function automatic decomp_t decompose_ref(input coeff_t r);
        int      r0;
        int      hi;
        decomp_t d;
        r0 = int'(r) % TWO_GAMMA2;
        if (r0 > GAMMA2) begin
            r0 = r0 - TWO_GAMMA2;
        end
        hi = int'(r) - r0;
        if (hi == DILITHIUM_Q - 1) begin
            d.r1 = '0;
            d.r0 = r0_t'(r0 - 1);
        end else begin
            d.r1 = r1_t'(hi / TWO_GAMMA2);
            d.r0 = r0_t'(r0);
        end
        return d;
    endfunction

    // Returns {norm, range}, the norm part only counts lanes that are in range
    function automatic logic [1:0] flags_ref(input coeff_vec_t v);
        logic    norm;
        logic    rng;
        int      a;
        decomp_t d;
        norm = 1'b0;
        rng  = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (v[k] >= DILITHIUM_Q) begin
                rng = 1'b1;
            end else begin
                d = decompose_ref(v[k]);
                a = d.r0;
                if (a < 0) begin
                    a = -a;
                end
                if (a >= GAMMA2 - BETA) begin
                    norm = 1'b1;
                end
            end
        end
        return {norm, rng};
    endfunction

    function automatic coeff_t rand_coeff();
        return coeff_t'({$random(seed)} % DILITHIUM_Q);
    endfunction

    // ------------------------------------------------------------------------
    // Compare tasks and compare process
    // ------------------------------------------------------------------------

    task automatic check_decomp(input string name, input decomp_t got, input decomp_t want);
        if (got !== want) begin
            value_errors++;
            $display("[FAIL] t=%0t %s got r1=%0d r0=%0d expected r1=%0d r0=%0d",
                     $time, name, got.r1, got.r0, want.r1, want.r0);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            value_errors++;
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // Outputs settle after the rising edge, so the falling edge is a safe place to look
    always @(negedge clk) begin : compare_proc
        expect_t want;
        if (reset_n && out_en) begin
            if (exp_q.size() == 0) begin
                misc_errors++;
                $display("Unexpected output at time %0t with no vector pending", $time);
            end else begin
                want = exp_q.pop_front();
                // Each result must show up a fixed number of cycles after its strobe
                if (cycle_cnt != want.due) begin
                    misc_errors++;
                    $display("Result arrived at cycle %0d but was due at cycle %0d",
                             cycle_cnt, want.due);
                end
                for (int k = 0; k < LANES; k++) begin
                    if (!want.skip[k]) begin
                        check_decomp($sformatf("res_o[%0d]", k), res[k], want.res[k]);
                    end
                end
                check_flag("range_err_o", range_err, want.rng);
                // The norm flag is undefined once a lane holds an out-of-range value
                if (!want.rng) begin
                    check_flag("norm_fail_o", norm_fail, want.norm);
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------

    task automatic send_vec(input coeff_vec_t v);
        expect_t e;
        for (int k = 0; k < LANES; k++) begin
            coeff[k]  = v[k];
            e.res[k]  = decompose_ref(v[k]);
            e.skip[k] = (v[k] >= DILITHIUM_Q);
        end
        {e.norm, e.rng} = flags_ref(v);
        e.due = cycle_cnt + LATENCY;
        in_en = 1'b1;
        exp_q.push_back(e);
        @(negedge clk);
        in_en = 1'b0;
    endtask

    task automatic send_random();
        coeff_vec_t v;
        for (int k = 0; k < LANES; k++) begin
            v[k] = rand_coeff();
        end
        send_vec(v);
    endtask

    // Collects single values into a vector and sends it once all lanes are filled
    task automatic add_value(input int value);
        pend[pend_n] = coeff_t'(value);
        pend_n++;
        if (pend_n == LANES) begin
            send_vec(pend);
            pend   = '0;
            pend_n = 0;
        end
    endtask

    task automatic drain();
        for (int i = 0; i < 12 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            misc_errors++;
            $display("No output arrived for %0d vectors at time %0t", exp_q.size(), $time);
            exp_q.delete();
        end
        repeat (2) @(negedge clk);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Watchdog expired at time %0t before the tests finished", $time);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin : main_proc
        coeff_vec_t v;
        int         m;
        int         bound;
        clk     = 1'b0;
        reset_n = 1'b0;
        zeroize = 1'b0;
        in_en   = 1'b0;
        pend    = '0;
        for (int k = 0; k < LANES; k++) begin
            coeff[k] = '0;
        end
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        repeat (2) @(negedge clk);

        // Boundary values around every multiple of 2*gamma2
        add_value(0);
        add_value(GAMMA2);
        add_value(GAMMA2 + 1);
        add_value(TWO_GAMMA2);
        add_value(DILITHIUM_Q - 1);
        add_value(DILITHIUM_Q - 2);
        for (int k = 0; k <= 16; k++) begin
            m = k * TWO_GAMMA2;
            if (m > 0) begin
                add_value(m - 1);
            end
            if (m + 1 < DILITHIUM_Q) begin
                add_value(m + 1);
            end
        end
        if (pend_n != 0) begin
            send_vec(pend);
        end
        drain();

        // Back to back, four vectors in flight at once
        repeat (RAND_VECS) send_random();
        drain();

        // Random idle gaps of one to four cycles between strobes
        repeat (SPARSE_VECS) begin
            send_random();
            repeat (1 + {$random(seed)} % 4) @(negedge clk);
        end
        drain();

        // |r0| just below, at and just above the norm bound, on both signs
        bound = GAMMA2 - BETA;
        for (int d = -1; d <= 1; d++) begin
            v = '0;
            v[d + 1] = coeff_t'(3 * TWO_GAMMA2 + bound + d);
            send_vec(v);
            v[d + 1] = coeff_t'(3 * TWO_GAMMA2 - (bound + d));
            send_vec(v);
        end
        drain();

        // Out-of-range vectors interleaved with clean ones, the bad lane rotates
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < LANES; k++) begin
                v[k] = rand_coeff();
            end
            send_vec(v);
            v[i % LANES] = coeff_t'(DILITHIUM_Q + {$random(seed)} % 8191);
            send_vec(v);
        end
        drain();

        // Zeroize with three vectors in flight, none of them may come out
        repeat (3) send_random();
        zeroize = 1'b1;
        exp_q.delete();
        @(negedge clk);
        zeroize = 1'b0;
        repeat (6) @(negedge clk);
        repeat (8) send_random();
        drain();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, misc_errors);
        if (value_errors == 0 && misc_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
common/decompose_pkg.sv
logic/coeff_distributor.sv
decompose_lane/mod_2gamma2.sv
decompose_lane/decompose_lane.sv
logic/decompose_collector.sv
logic/decompose_top.sv
verification/decompose_tb.sv

//--- Bender.yml
package:
  name: decompose

sources:
  - files:
      - common/decompose_pkg.sv
      - logic/coeff_distributor.sv
      - decompose_lane/mod_2gamma2.sv
      - decompose_lane/decompose_lane.sv
      - logic/decompose_collector.sv
      - logic/decompose_top.sv
  - target: test
    files:
      - verification/decompose_tb.sv
